//--- compile.f
+incdir+.
gemm_pkg.sv
dma_engine.sv
beat_packer.sv
operand_buffer.sv
outer_product_array.sv
gemm_top.sv
tb_axi_mem.sv
tb_gemm.sv

//--- Makefile
# Verilator simulation of the gemm accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_gemm
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= *** PASSED ***

.PHONY: sim clean

# the exit status comes from the grep on the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_STR)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_gemm.sv
// gemm accelerator testbench
// runs a table of tile jobs through the DUT and an AXI memory model,
// checks requests, W beats, done pulses and the whole memory image
`timescale 1ns/1ps
`include "gemm_config.svh"

module tb_gemm;
    import gemm_pkg::*;

    localparam int TILE      = `GEMM_SA_W;
    localparam int ELEMS     = TILE * TILE;
    localparam int MEM_AW    = 8;
    localparam int MEM_WORDS = 1 << MEM_AW;
    localparam int NUM_JOBS  = 5;
    localparam int WATCHDOG_CYCLES = NUM_JOBS * 3000;

    // elements in row-major order, index row*TILE+col
    typedef logic [ELEMS-1:0][31:0] tile_t;

    typedef struct packed {
        tile_t       a;
        tile_t       b;
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] c_addr;
        logic        stall;
    } job_t;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        done;
    logic [31:0] a_addr;
    logic [31:0] b_addr;
    logic [31:0] c_addr;
    axi_ar_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;
    axi_aw_t     aw;
    logic        aw_valid;
    logic        aw_ready;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready;
    logic        b_valid;
    logic        b_ready;
    logic        stall_en;
    logic        ld_en;
    logic [MEM_AW-1:0] ld_addr;
    logic [31:0] ld_data;

    job_t        jobs [NUM_JOBS];
    tile_t       exp_c [NUM_JOBS];
    // mirror of what memory should hold
    logic [31:0] exp_mem [MEM_WORDS];
    logic [15:0] rnd_state = 16'd37141;
    int          n_checks = 0;
    int          n_errors = 0;
    int          done_count = 0;
    axi_ar_t     ar_seen [$];
    axi_aw_t     aw_seen [$];
    axi_w_t      w_seen [$];

    gemm_top i_gemm_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .mat_a_addr_i (a_addr),
        .mat_b_addr_i (b_addr),
        .mat_c_addr_i (c_addr),
        .done_o       (done),
        .ar_o         (ar),
        .ar_valid_o   (ar_valid),
        .ar_ready_i   (ar_ready),
        .r_i          (r),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .aw_o         (aw),
        .aw_valid_o   (aw_valid),
        .aw_ready_i   (aw_ready),
        .w_o          (w),
        .w_valid_o    (w_valid),
        .w_ready_i    (w_ready),
        .b_valid_i    (b_valid),
        .b_ready_o    (b_ready)
    );

    tb_axi_mem #(.MEM_AW(MEM_AW)) i_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_en_i (stall_en),
        .ld_en_i    (ld_en),
        .ld_addr_i  (ld_addr),
        .ld_data_i  (ld_data),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] v;
        v = '0;
        for (int n = 0; n < 32; n++) begin
            rnd_state = lfsr_next(rnd_state);
            v = {v[30:0], rnd_state[0]};
        end
        return v;
    endfunction

    // C[i][j] = sum over k of A[i][k] * B[k][j], low 32 bits
    function automatic tile_t ref_gemm(input tile_t a, input tile_t b);
        tile_t c;
        int    acc;
        for (int i = 0; i < TILE; i++) begin
            for (int j = 0; j < TILE; j++) begin
                acc = 0;
                for (int k = 0; k < TILE; k++)
                    acc += int'(a[i*TILE + k]) * int'(b[k*TILE + j]);
                c[i*TILE + j] = acc;
            end
        end
        return c;
    endfunction

    // background pattern, every address bit shows up in the word
    function automatic logic [31:0] fill_word(input int addr);
        return {16'hc0de ^ 16'(addr), 16'(addr << 2)};
    endfunction

    task automatic build_table();
        for (int e = 0; e < ELEMS; e++) begin
            // identity times B
            jobs[0].a[e] = (e / TILE == e % TILE) ? 32'd1 : 32'd0;
            jobs[0].b[e] = 32'(e) * 32'h0102_0305 + 32'd9;
            // large positive and negative operands
            jobs[1].a[e] = (e % 2 == 1) ? 32'h8000_0000 + 32'(e) * 32'h0011_0101
                                        : -(32'(e) * 32'd65537 + 32'd1);
            jobs[1].b[e] = (e % 3 == 0) ? 32'h7fff_ffff - 32'(e)
                                        : 32'hffff_0000 ^ (32'(e) * 32'h0123_4567);
        end
        for (int n = 2; n < NUM_JOBS; n++) begin
            for (int e = 0; e < ELEMS; e++) begin
                jobs[n].a[e] = random_word();
                jobs[n].b[e] = random_word();
            end
        end
        jobs[0].a_addr = 32'h000;
        jobs[0].b_addr = 32'h040;
        jobs[0].c_addr = 32'h080;
        jobs[0].stall  = 1'b0;
        jobs[1].a_addr = 32'h100;
        jobs[1].b_addr = 32'h140;
        jobs[1].c_addr = 32'h180;
        jobs[1].stall  = 1'b1;
        // jobs 2 and 3 share addresses, so stale results would show
        for (int n = 2; n < 4; n++) begin
            jobs[n].a_addr = 32'h200;
            jobs[n].b_addr = 32'h240;
            jobs[n].c_addr = 32'h280;
            jobs[n].stall  = 1'b1;
        end
        // overwrites the C of job 0
        jobs[4].a_addr = 32'h2c0;
        jobs[4].b_addr = 32'h300;
        jobs[4].c_addr = 32'h080;
        jobs[4].stall  = 1'b0;
        for (int n = 0; n < NUM_JOBS; n++)
            exp_c[n] = ref_gemm(jobs[n].a, jobs[n].b);
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_aw(input axi_aw_t got, input axi_aw_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_word(input int addr, input logic [31:0] data);
        @(posedge clk);
        ld_en   <= 1'b1;
        ld_addr <= MEM_AW'(addr);
        ld_data <= data;
        exp_mem[addr] = data;
    endtask

    // record every handshake seen on the DUT ports
    always @(posedge clk) begin
        if (rst_n) begin
            if (ar_valid && ar_ready)
                ar_seen.push_back(ar);
            if (aw_valid && aw_ready)
                aw_seen.push_back(aw);
            if (w_valid && w_ready)
                w_seen.push_back(w);
            if (done)
                done_count <= done_count + 1;
        end
    end

    task automatic run_job(input int n);
        int      a_word;
        int      b_word;
        int      c_word;
        int      ar_start;
        int      aw_start;
        int      w_start;
        int      done_start;
        logic    b_prev;
        logic    b_fire;
        axi_ar_t exp_ar;
        axi_aw_t exp_aw;
        a_word = int'(jobs[n].a_addr >> 2);
        b_word = int'(jobs[n].b_addr >> 2);
        c_word = int'(jobs[n].c_addr >> 2);
        // A column-major, B row-major
        for (int i = 0; i < TILE; i++) begin
            for (int j = 0; j < TILE; j++) begin
                load_word(a_word + j*TILE + i, jobs[n].a[i*TILE + j]);
                load_word(b_word + i*TILE + j, jobs[n].b[i*TILE + j]);
            end
        end
        for (int e = 0; e < ELEMS; e++)
            exp_mem[c_word + e] = exp_c[n][e];
        ar_start   = ar_seen.size();
        aw_start   = aw_seen.size();
        w_start    = w_seen.size();
        done_start = done_count;
        @(posedge clk);
        // handshake outputs and done stay low between jobs
        check_word(32'({ar_valid, r_ready, aw_valid, w_valid, b_ready, done}), 32'd0,
                   $sformatf("job %0d idle outputs", n));
        ld_en    <= 1'b0;
        stall_en <= jobs[n].stall;
        a_addr   <= jobs[n].a_addr;
        b_addr   <= jobs[n].b_addr;
        c_addr   <= jobs[n].c_addr;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        b_fire = 1'b0;
        // b_prev ends as the B handshake of the cycle before done
        do begin
            b_prev = b_fire;
            @(posedge clk);
            b_fire = b_valid && b_ready;
        end while (done !== 1'b1);
        // room for a stray second pulse
        repeat (3) @(posedge clk);

        check_word(32'(b_prev), 32'd1, $sformatf("job %0d done after B handshake", n));
        check_word(32'(done_count - done_start), 32'd1, $sformatf("job %0d done pulses", n));
        check_word(32'(ar_seen.size() - ar_start), 32'd2, $sformatf("job %0d AR count", n));
        exp_ar.id    = 1'b0;
        exp_ar.addr  = jobs[n].a_addr;
        exp_ar.len   = 8'd15;
        exp_ar.size  = 3'd2;
        exp_ar.burst = 2'b01;
        if (ar_seen.size() - ar_start == 2) begin
            check_ar(ar_seen[ar_start], exp_ar, $sformatf("job %0d AR for A", n));
            exp_ar.id   = 1'b1;
            exp_ar.addr = jobs[n].b_addr;
            check_ar(ar_seen[ar_start + 1], exp_ar, $sformatf("job %0d AR for B", n));
        end
        check_word(32'(aw_seen.size() - aw_start), 32'd1, $sformatf("job %0d AW count", n));
        exp_aw.id    = 1'b0;
        exp_aw.addr  = jobs[n].c_addr;
        exp_aw.len   = 8'd15;
        exp_aw.size  = 3'd2;
        exp_aw.burst = 2'b01;
        if (aw_seen.size() - aw_start == 1)
            check_aw(aw_seen[aw_start], exp_aw, $sformatf("job %0d AW", n));
        check_word(32'(w_seen.size() - w_start), 32'(ELEMS), $sformatf("job %0d W beats", n));
        for (int b = 0; b < w_seen.size() - w_start; b++) begin
            check_word(32'(w_seen[w_start + b].last), 32'(b == ELEMS - 1),
                       $sformatf("job %0d W beat %0d last", n, b));
            check_word(32'(w_seen[w_start + b].strb), 32'hf,
                       $sformatf("job %0d W beat %0d strb", n, b));
        end
        // C region and everything around it
        for (int m = 0; m < MEM_WORDS; m++)
            check_word(i_mem.mem[m], exp_mem[m], $sformatf("job %0d mem word %0d", n, m));
    endtask

    initial begin
        start    = 1'b0;
        a_addr   = '0;
        b_addr   = '0;
        c_addr   = '0;
        stall_en = 1'b0;
        ld_en    = 1'b0;
        ld_addr  = '0;
        ld_data  = '0;
        rst_n    = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int m = 0; m < MEM_WORDS; m++)
            load_word(m, fill_word(m));
        for (int n = 0; n < NUM_JOBS; n++)
            run_job(n);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT never signalled done",
                 WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- tb_axi_mem.sv
// AXI slave memory model for the gemm testbench
// in-order read bursts, one write burst at a time, LFSR driven stalls
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter int MEM_AW = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall_en_i,
    input  logic              ld_en_i,
    input  logic [MEM_AW-1:0] ld_addr_i,
    input  logic [31:0]       ld_data_i,
    input  gemm_pkg::axi_ar_t ar_i,
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    output gemm_pkg::axi_r_t  r_o,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    input  gemm_pkg::axi_aw_t aw_i,
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  gemm_pkg::axi_w_t  w_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    output logic              b_valid_o,
    input  logic              b_ready_i
);
    import gemm_pkg::*;

    localparam int MEM_WORDS = 1 << MEM_AW;

    logic [31:0] mem [MEM_WORDS];
    // accepted read requests, served in order
    axi_ar_t     ar_q [$];

    // known values before the first clock edge
    logic        ar_ready_q = 1'b0;
    logic        aw_ready_q = 1'b0;
    logic        w_ready_q  = 1'b0;
    logic        r_valid_q  = 1'b0;
    logic        b_valid_q  = 1'b0;
    axi_r_t      r_q        = '0;
    logic [15:0] stall_lfsr = 16'd37141;

    logic              rd_busy;
    logic              rd_id;
    logic [MEM_AW-1:0] rd_base;
    logic [7:0]        rd_len;
    logic [7:0]        rd_cnt;
    logic [MEM_AW-1:0] wr_base;
    logic [MEM_AW-1:0] wr_cnt;
    logic              b_pend;

    assign ar_ready_o = ar_ready_q;
    assign aw_ready_o = aw_ready_q;
    assign w_ready_o  = w_ready_q;
    assign r_valid_o  = r_valid_q;
    assign r_o        = r_q;
    assign b_valid_o  = b_valid_q;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step per bit, always ready when stalls are off
    function automatic logic ready_bit();
        if (!stall_en_i)
            return 1'b1;
        stall_lfsr = lfsr_next(stall_lfsr);
        return stall_lfsr[0];
    endfunction

    always @(posedge clk) begin
        // preload port from the testbench
        if (ld_en_i)
            mem[ld_addr_i] <= ld_data_i;
        if (!rst_n) begin
            ar_ready_q <= 1'b0;
            aw_ready_q <= 1'b0;
            w_ready_q  <= 1'b0;
            r_valid_q  <= 1'b0;
            b_valid_q  <= 1'b0;
            rd_busy    <= 1'b0;
            b_pend     <= 1'b0;
            ar_q.delete();
        end else begin
            ar_ready_q <= ready_bit();
            aw_ready_q <= ready_bit();
            w_ready_q  <= ready_bit();
            if (ar_valid_i && ar_ready_q)
                ar_q.push_back(ar_i);
            // beat taken, may be replaced below
            if (r_valid_q && r_ready_i)
                r_valid_q <= 1'b0;
            if (!rd_busy) begin
                if (ar_q.size() != 0) begin
                    rd_busy <= 1'b1;
                    rd_id   <= ar_q[0].id;
                    rd_base <= ar_q[0].addr[MEM_AW+1:2];
                    rd_len  <= ar_q[0].len;
                    rd_cnt  <= '0;
                    ar_q.delete(0);
                end
            end else if (!r_valid_q || r_ready_i) begin
                // random gap before the next beat
                if (ready_bit()) begin
                    r_valid_q <= 1'b1;
                    r_q.id    <= rd_id;
                    r_q.data  <= mem[rd_base + MEM_AW'(rd_cnt)];
                    r_q.last  <= (rd_cnt == rd_len);
                    rd_cnt    <= rd_cnt + 1'b1;
                    if (rd_cnt == rd_len)
                        rd_busy <= 1'b0;
                end
            end
            // one response per write burst
            if (b_valid_q && b_ready_i) begin
                b_valid_q <= 1'b0;
            end else if (b_pend && !b_valid_q) begin
                if (ready_bit()) begin
                    b_valid_q <= 1'b1;
                    b_pend    <= 1'b0;
                end
            end
            if (aw_valid_i && aw_ready_q) begin
                wr_base <= aw_i.addr[MEM_AW+1:2];
                wr_cnt  <= '0;
            end
            // every accepted beat lands in the array
            if (w_valid_i && w_ready_q) begin
                mem[wr_base + wr_cnt] <= w_i.data;
                wr_cnt <= wr_cnt + 1'b1;
                if (w_i.last)
                    b_pend <= 1'b1;
            end
        end
    end

endmodule

//--- gemm_top.sv
// gemm accelerator top level
// DMA engine, two beat packers, two operand buffers and the array
`timescale 1ns/1ps
`include "gemm_config.svh"

module gemm_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic [31:0]       mat_a_addr_i,
    input  logic [31:0]       mat_b_addr_i,
    input  logic [31:0]       mat_c_addr_i,
    output logic              done_o,
    output gemm_pkg::axi_ar_t ar_o,
    output logic              ar_valid_o,
    input  logic              ar_ready_i,
    input  gemm_pkg::axi_r_t  r_i,
    input  logic              r_valid_i,
    output logic              r_ready_o,
    output gemm_pkg::axi_aw_t aw_o,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output gemm_pkg::axi_w_t  w_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    input  logic              b_valid_i,
    output logic              b_ready_o
);
    import gemm_pkg::*;

    logic                    beat_a;
    logic                    beat_b;
    logic [`GEMM_BUF_AW:0]   words_a;
    logic [`GEMM_BUF_AW:0]   words_b;
    buf_wr_t                 wr_a;
    buf_wr_t                 wr_b;
    logic                    wr_en_a;
    logic                    wr_en_b;
    logic [`GEMM_BUF_AW-1:0] raddr;
    logic [`GEMM_BUF_DW-1:0] a_col;
    logic [`GEMM_BUF_DW-1:0] b_row;
    logic                    mm_start;
    logic                    mm_done;
    c_tile_t                 tile;

    dma_engine i_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .done_o       (done_o),
        .ar_o         (ar_o),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .r_valid_i    (r_valid_i),
        .r_id_i       (r_i.id),
        .r_ready_o    (r_ready_o),
        .beat_a_o     (beat_a),
        .beat_b_o     (beat_b),
        .aw_o         (aw_o),
        .aw_valid_o   (aw_valid_o),
        .aw_ready_i   (aw_ready_i),
        .w_o          (w_o),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .b_valid_i    (b_valid_i),
        .b_ready_o    (b_ready_o),
        .words_a_i    (words_a),
        .words_b_i    (words_b),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .tile_i       (tile)
    );

    // both packers see all R data, strobes pick the owner
    beat_packer i_pack_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat_i  (beat_a),
        .data_i  (r_i.data),
        .wr_o    (wr_a),
        .wr_en_o (wr_en_a),
        .words_o (words_a)
    );

    beat_packer i_pack_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat_i  (beat_b),
        .data_i  (r_i.data),
        .wr_o    (wr_b),
        .wr_en_o (wr_en_b),
        .words_o (words_b)
    );

    operand_buffer i_buf_a (
        .clk     (clk),
        .wr_i    (wr_a),
        .wr_en_i (wr_en_a),
        .raddr_i (raddr),
        .rdata_o (a_col)
    );

    operand_buffer i_buf_b (
        .clk     (clk),
        .wr_i    (wr_b),
        .wr_en_i (wr_en_b),
        .raddr_i (raddr),
        .rdata_o (b_row)
    );

    outer_product_array i_opa (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mm_start),
        .raddr_o (raddr),
        .a_col_i (a_col),
        .b_row_i (b_row),
        .done_o  (mm_done),
        .tile_o  (tile)
    );

endmodule

//--- outer_product_array.sv
// 4x4 outer-product multiply-accumulate array
// one clear cycle then one rank-1 update per buffer word k
`timescale 1ns/1ps
`include "gemm_config.svh"

module outer_product_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    output logic [`GEMM_BUF_AW-1:0] raddr_o,
    input  logic [`GEMM_BUF_DW-1:0] a_col_i,
    input  logic [`GEMM_BUF_DW-1:0] b_row_i,
    output logic                    done_o,
    output gemm_pkg::c_tile_t       tile_o
);
    import gemm_pkg::*;

    localparam logic [`GEMM_BUF_AW-1:0] LAST_K = `GEMM_BUF_AW'(`GEMM_SA_W - 1);

    logic                    busy;
    logic [`GEMM_BUF_AW-1:0] k;
    c_tile_t                 acc;
    logic signed [`GEMM_DW-1:0] a_lane [`GEMM_SA_W];
    logic signed [`GEMM_DW-1:0] b_lane [`GEMM_SA_W];

    // same k addresses column of A and row of B
    assign raddr_o = k;
    assign tile_o  = acc;

    // lane i of A column is row i, lane j of B row is col j
    always_comb begin
        for (int n = 0; n < `GEMM_SA_W; n++) begin
            a_lane[n] = a_col_i[n*`GEMM_DW +: `GEMM_DW];
            b_lane[n] = b_row_i[n*`GEMM_DW +: `GEMM_DW];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            k      <= '0;
            done_o <= 1'b0;
        end else begin
            // done lands five cycles after start
            done_o <= busy && (k == LAST_K);
            if (start_i) begin
                busy <= 1'b1;
                k    <= '0;
            end else if (busy) begin
                k <= k + 1'b1;
                if (k == LAST_K)
                    busy <= 1'b0;
            end
        end
    end

    // results hold until the next start
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc <= '0;
        end else if (busy) begin
            for (int i = 0; i < `GEMM_SA_W; i++) begin
                for (int j = 0; j < `GEMM_SA_W; j++) begin
                    // wraps mod 2^32
                    acc[i][j] <= $signed(acc[i][j]) + a_lane[i] * b_lane[j];
                end
            end
        end
    end

endmodule

//--- operand_buffer.sv
// operand tile buffer
// four words, registered write, combinational read
`timescale 1ns/1ps
`include "gemm_config.svh"

module operand_buffer (
    input  logic                    clk,
    input  gemm_pkg::buf_wr_t       wr_i,
    input  logic                    wr_en_i,
    input  logic [`GEMM_BUF_AW-1:0] raddr_i,
    output logic [`GEMM_BUF_DW-1:0] rdata_o
);
    localparam int DEPTH = 1 << `GEMM_BUF_AW;

    logic [`GEMM_BUF_DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i)
            mem[wr_i.addr] <= wr_i.data;
    end

    // array indexes this directly each step
    assign rdata_o = mem[raddr_i];

endmodule

//--- beat_packer.sv
// read beat packer
// gathers four accepted 32-bit beats into one operand buffer word
`timescale 1ns/1ps
`include "gemm_config.svh"

module beat_packer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  beat_i,
    input  logic [`GEMM_DW-1:0]   data_i,
    output gemm_pkg::buf_wr_t     wr_o,
    output logic                  wr_en_o,
    output logic [`GEMM_BUF_AW:0] words_o
);
    localparam int LANE_W = $clog2(`GEMM_SA_W);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`GEMM_SA_W - 1);
    localparam logic [`GEMM_BUF_AW:0] FULL_WORDS = (`GEMM_BUF_AW + 1)'(1 << `GEMM_BUF_AW);

    logic [LANE_W-1:0]       lane;
    logic [`GEMM_BUF_AW-1:0] waddr;
    logic [`GEMM_BUF_DW-1:0] shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane    <= '0;
            waddr   <= '0;
            wr_en_o <= 1'b0;
            words_o <= '0;
        end else begin
            // write strobe one cycle after the last lane
            wr_en_o <= beat_i && (lane == LAST_LANE);
            if (beat_i)
                lane <= lane + 1'b1;
            if (wr_en_o) begin
                waddr   <= waddr + 1'b1;
                words_o <= words_o + 1'b1;
            end else if (words_o == FULL_WORDS) begin
                // address has wrapped, tile done
                words_o <= '0;
            end
        end
    end

    // first beat ends up in the lowest lane
    always_ff @(posedge clk) begin
        if (beat_i)
            shift_q <= {data_i, shift_q[`GEMM_BUF_DW-1:`GEMM_DW]};
    end

    always_comb begin
        wr_o.addr = waddr;
        wr_o.data = shift_q;
    end

endmodule

//--- dma_engine.sv
// gemm DMA engine
// fetches A and B over AXI reads, starts the outer-product array,
// then writes C back in one burst and pulses done on the B response
`timescale 1ns/1ps
`include "gemm_config.svh"

module dma_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [31:0]           mat_a_addr_i,
    input  logic [31:0]           mat_b_addr_i,
    input  logic [31:0]           mat_c_addr_i,
    output logic                  done_o,
    output gemm_pkg::axi_ar_t     ar_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    input  logic                  r_valid_i,
    input  logic                  r_id_i,
    output logic                  r_ready_o,
    output logic                  beat_a_o,
    output logic                  beat_b_o,
    output gemm_pkg::axi_aw_t     aw_o,
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output gemm_pkg::axi_w_t      w_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    input  logic                  b_valid_i,
    output logic                  b_ready_o,
    input  logic [`GEMM_BUF_AW:0] words_a_i,
    input  logic [`GEMM_BUF_AW:0] words_b_i,
    output logic                  mm_start_o,
    input  logic                  mm_done_i,
    input  gemm_pkg::c_tile_t     tile_i
);
    import gemm_pkg::*;

    localparam int BEAT_CW = $clog2(`GEMM_BURST_LEN);
    localparam int LANE_W  = $clog2(`GEMM_SA_W);
    localparam logic [`GEMM_BUF_AW:0] FULL_WORDS = (`GEMM_BUF_AW + 1)'(1 << `GEMM_BUF_AW);
    localparam logic [BEAT_CW-1:0] LAST_BEAT = BEAT_CW'(`GEMM_BURST_LEN - 1);
    // burst fields shared by AR and AW
    localparam logic [7:0] AXI_LEN  = 8'(`GEMM_BURST_LEN - 1);
    localparam logic [2:0] AXI_SIZE = 3'($clog2(`GEMM_DW / 8));
    localparam logic [1:0] AXI_INCR = 2'b01;

    dma_state_e state;
    dma_state_e state_nxt;

    logic [31:0]        a_addr_q;
    logic [31:0]        b_addr_q;
    logic [31:0]        c_addr_q;
    logic               a_full_q;
    logic               b_full_q;
    logic               a_full;
    logic               b_full;
    logic [BEAT_CW-1:0] beat_cnt;
    logic               w_fire;
    logic               w_last;

    // packer count shows full for one cycle only, so keep a sticky copy
    assign a_full = a_full_q || (words_a_i == FULL_WORDS);
    assign b_full = b_full_q || (words_b_i == FULL_WORDS);

    assign w_last = (beat_cnt == LAST_BEAT);
    assign w_fire = w_valid_o && w_ready_i;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:
                if (start_i)
                    state_nxt = ADDR_A;
            ADDR_A:
                if (ar_ready_i)
                    state_nxt = ADDR_B;
            ADDR_B:
                if (ar_ready_i)
                    state_nxt = LOAD;
            // both bursts may interleave here
            LOAD:
                if (a_full && b_full)
                    state_nxt = RUN_MM;
            RUN_MM:
                if (mm_done_i)
                    state_nxt = ADDR_C;
            ADDR_C:
                if (aw_ready_i)
                    state_nxt = WRITE_C;
            WRITE_C:
                if (w_fire && w_last)
                    state_nxt = WAIT_B;
            WAIT_B:
                if (b_valid_i)
                    state_nxt = IDLE;
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            a_full_q   <= 1'b0;
            b_full_q   <= 1'b0;
            beat_cnt   <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            state      <= state_nxt;
            // single pulse on entry to RUN_MM
            mm_start_o <= (state == LOAD) && (state_nxt == RUN_MM);
            // cycle after the B handshake
            done_o     <= b_ready_o && b_valid_i;
            if (state_nxt == LOAD) begin
                a_full_q <= a_full;
                b_full_q <= b_full;
            end else begin
                a_full_q <= 1'b0;
                b_full_q <= 1'b0;
            end
            if (w_fire)
                beat_cnt <= w_last ? '0 : beat_cnt + 1'b1;
        end
    end

    // job addresses captured on start
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            a_addr_q <= mat_a_addr_i;
            b_addr_q <= mat_b_addr_i;
            c_addr_q <= mat_c_addr_i;
        end
    end

    // read address, A then B
    assign ar_valid_o = (state == ADDR_A) || (state == ADDR_B);
    always_comb begin
        ar_o.id    = (state == ADDR_B);
        ar_o.addr  = (state == ADDR_B) ? b_addr_q : a_addr_q;
        ar_o.len   = AXI_LEN;
        ar_o.size  = AXI_SIZE;
        ar_o.burst = AXI_INCR;
    end

    // read data steered by id
    assign r_ready_o = (state == LOAD);
    assign beat_a_o  = r_ready_o && r_valid_i && !r_id_i;
    assign beat_b_o  = r_ready_o && r_valid_i && r_id_i;

    assign aw_valid_o = (state == ADDR_C);
    always_comb begin
        aw_o.id    = 1'b0;
        aw_o.addr  = c_addr_q;
        aw_o.len   = AXI_LEN;
        aw_o.size  = AXI_SIZE;
        aw_o.burst = AXI_INCR;
    end

    // beat n carries row n/4, col n%4
    assign w_valid_o = (state == WRITE_C);
    always_comb begin
        w_o.data = tile_i[beat_cnt[BEAT_CW-1:LANE_W]][beat_cnt[LANE_W-1:0]];
        w_o.strb = 4'hf;
        w_o.last = w_last;
    end

    assign b_ready_o = (state == WAIT_B);

endmodule

//--- gemm_pkg.sv
// gemm accelerator shared types
// FSM states, AXI channel payloads, buffer writes and the result tile
`include "gemm_config.svh"

package gemm_pkg;

    typedef enum logic [2:0] {
        IDLE,
        ADDR_A,
        ADDR_B,
        LOAD,
        RUN_MM,
        ADDR_C,
        WRITE_C,
        WAIT_B
    } dma_state_e;

    // read address, 46 bits
    typedef struct packed {
        logic        id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // write address, same layout as AR
    typedef struct packed {
        logic        id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef struct packed {
        logic        id;
        logic [31:0] data;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // one write into an operand buffer
    typedef struct packed {
        logic [`GEMM_BUF_AW-1:0] addr;
        logic [`GEMM_BUF_DW-1:0] data;
    } buf_wr_t;

    // results indexed [row][col]
    typedef logic signed [`GEMM_SA_W-1:0][`GEMM_SA_W-1:0][`GEMM_DW-1:0] c_tile_t;

endpackage

//--- gemm_config.svh
// gemm tile configuration
// fixed 4x4 tile of 32-bit elements, one burst per matrix
`ifndef GEMM_CONFIG_SVH
`define GEMM_CONFIG_SVH

// tile side in elements
`define GEMM_SA_W 4

// element width in bits
`define GEMM_DW 32

// operand buffer address width, one word per column or row
`define GEMM_BUF_AW 2

// one buffer word holds a full column of A or row of B
`define GEMM_BUF_DW (`GEMM_SA_W * `GEMM_DW)

// beats per AXI burst, one per tile element
`define GEMM_BURST_LEN 16

`endif
